//--- source/jt12_pkg.sv
// Shared constants for the FM chip control core.
// Holds the register map, clock divider ratios and bus widths.
// Modules take it with a wildcard import in their body.
`default_nettype none

package jt12_pkg;

    // Register map of bank 0
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;  // Timer A bits 9..2
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;  // Timer A bits 1..0
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL  = 8'h27;  // Load, irq enable, flag reset
    localparam logic [7:0] REG_DAC_DATA   = 8'h2A;  // Offset binary sample
    localparam logic [7:0] REG_DAC_EN     = 8'h2B;  // Bit 7 enables the DAC

    // Divider ratios
    localparam int CEN_DIV     = 6;   // cen pulses per clk_en
    localparam int SAMPLE_DIV  = 24;  // clk_en pulses per sample
    localparam int TIMER_B_DIV = 16;  // Samples per timer B tick
    localparam int BUSY_LEN    = 32;  // clk_en pulses of busy after a write

    // Data widths
    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;
    localparam int SND_W     = 16;
    localparam int DAC_SHIFT = 7;

    // Counter widths and terminal counts
    localparam int CEN_CNT_W  = $clog2(CEN_DIV);
    localparam int SMP_CNT_W  = $clog2(SAMPLE_DIV);
    localparam int TB_PRE_W   = $clog2(TIMER_B_DIV);
    localparam int BUSY_CNT_W = $clog2(BUSY_LEN);

    localparam logic [CEN_CNT_W-1:0]  CEN_LAST  = CEN_CNT_W'(CEN_DIV - 1);
    localparam logic [SMP_CNT_W-1:0]  SMP_LAST  = SMP_CNT_W'(SAMPLE_DIV - 1);
    localparam logic [TB_PRE_W-1:0]   TB_LAST   = TB_PRE_W'(TIMER_B_DIV - 1);
    localparam logic [BUSY_CNT_W-1:0] BUSY_LAST = BUSY_CNT_W'(BUSY_LEN - 1);

endpackage

`default_nettype wire

//--- source/jt12_clkgen.sv
// Internal clock enable generation.
// Divides cen down to clk_en, then marks every sample with zero.
`default_nettype none

module jt12_clkgen (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  cen,     // External clock enable
    output logic clk_en,  // Internal clock enable
    output logic zero     // Start of sample
);

    import jt12_pkg::*;

    logic [CEN_CNT_W-1:0] pre_cnt;
    logic [SMP_CNT_W-1:0] smp_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            smp_cnt <= '0;
            clk_en  <= 1'b0;
            zero    <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            zero   <= 1'b0;
            if (cen) begin
                if (pre_cnt == CEN_LAST) begin
                    pre_cnt <= '0;
                    clk_en  <= 1'b1;
                    // Sample counter advances once per clk_en
                    if (smp_cnt == SMP_LAST) begin
                        smp_cnt <= '0;
                        zero    <= 1'b1;
                    end else begin
                        smp_cnt <= smp_cnt + 1'b1;
                    end
                end else begin
                    pre_cnt <= pre_cnt + 1'b1;
                end
            end
        end
    end

    // Sample start must line up with an internal enable
    assert property (@(posedge clk) disable iff (!rst_n) zero |-> clk_en);

endmodule

`default_nettype wire

//--- source/jt12_regs.sv
// CPU bus interface and register file.
// Latches the register address, decodes data writes into timer and
// DAC settings, runs the busy timer and muxes the status byte onto dout.
`default_nettype none

module jt12_regs (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            clk_en,
    input  wire  [7:0]                     din,
    input  wire  [1:0]                     addr,
    input  wire                            cs_n,
    input  wire                            wr_n,
    input  wire                            flag_a,
    input  wire                            flag_b,
    output logic [7:0]                     dout,
    output logic                           busy,
    output logic [jt12_pkg::TIMER_A_W-1:0] value_a,
    output logic [jt12_pkg::TIMER_B_W-1:0] value_b,
    output logic                           load_a,
    output logic                           load_b,
    output logic                           irq_en_a,
    output logic                           irq_en_b,
    output logic                           clr_flag_a,
    output logic                           clr_flag_b,
    output logic [7:0]                     dac_data,
    output logic                           dac_en
);

    import jt12_pkg::*;

    logic                  write;
    logic                  addr_wr;
    logic                  data_wr;
    logic [7:0]            sel_reg;    // Latched register address
    logic [BUSY_CNT_W-1:0] busy_cnt;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];  // addr[1] ignored, single bank

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_reg    <= '0;
            value_a    <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            dac_data   <= '0;
            dac_en     <= 1'b0;
        end else begin
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            if (addr_wr) begin
                sel_reg <= din;
            end
            if (data_wr) begin
                case (sel_reg)
                    REG_TIMER_A_HI: value_a[9:2] <= din;
                    REG_TIMER_A_LO: value_a[1:0] <= din[1:0];
                    REG_TIMER_B:    value_b      <= din;
                    REG_TIMER_CTL: begin
                        load_a     <= din[0];
                        load_b     <= din[1];
                        irq_en_a   <= din[2];
                        irq_en_b   <= din[3];
                        clr_flag_a <= din[4];
                        clr_flag_b <= din[5];
                    end
                    REG_DAC_DATA:   dac_data     <= din;
                    REG_DAC_EN:     dac_en       <= din[7];
                    default: ;                   // Unmapped, ignored
                endcase
            end
        end
    end

    // Busy lasts BUSY_LEN clk_en pulses, restarted by every data write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (busy && clk_en) begin
            if (busy_cnt == BUSY_LAST) begin
                busy <= 1'b0;
            end else begin
                busy_cnt <= busy_cnt + 1'b1;
            end
        end
    end

    // Status read-back
    always_comb begin
        dout = 8'h00;
        if (!addr[0]) begin
            dout = {busy, 5'b00000, flag_b, flag_a};
        end
    end

    // Flag clears reach the timers as single clock pulses
    assert property (@(posedge clk) disable iff (!rst_n) clr_flag_a |=> !clr_flag_a);
    assert property (@(posedge clk) disable iff (!rst_n) clr_flag_b |=> !clr_flag_b);

endmodule

`default_nettype wire

//--- source/jt12_timers.sv
// Timer A and timer B with overflow flags and the interrupt line.
// Timer A ticks every sample, timer B every TIMER_B_DIV samples.
// Both count up from their reload value while loaded.
`default_nettype none

module jt12_timers (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            zero,
    input  wire  [jt12_pkg::TIMER_A_W-1:0] value_a,
    input  wire  [jt12_pkg::TIMER_B_W-1:0] value_b,
    input  wire                            load_a,
    input  wire                            load_b,
    input  wire                            irq_en_a,
    input  wire                            irq_en_b,
    input  wire                            clr_flag_a,
    input  wire                            clr_flag_b,
    output logic                           flag_a,
    output logic                           flag_b,
    output logic                           irq_n
);

    import jt12_pkg::*;

    logic [TIMER_A_W-1:0] cnt_a;
    logic [TIMER_B_W-1:0] cnt_b;
    logic [TB_PRE_W-1:0]  pre_b;   // Samples into the current B tick
    logic                 tick_b;
    logic                 ovf_a;
    logic                 ovf_b;

    assign tick_b = load_b && zero && (pre_b == TB_LAST);
    assign ovf_a  = load_a && zero && (&cnt_a);
    assign ovf_b  = tick_b && (&cnt_b);

    // Timer A
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_a <= '0;
        end else if (!load_a) begin
            cnt_a <= value_a;           // Hold reload value while stopped
        end else if (zero) begin
            cnt_a <= ovf_a ? value_a : cnt_a + 1'b1;
        end
    end

    // Timer B and its sample prescaler
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_b <= '0;
            pre_b <= '0;
        end else if (!load_b) begin
            cnt_b <= value_b;
            pre_b <= '0;
        end else if (zero) begin
            pre_b <= pre_b + 1'b1;      // Wraps every TIMER_B_DIV samples
            if (tick_b) begin
                cnt_b <= ovf_b ? value_b : cnt_b + 1'b1;
            end
        end
    end

    // Sticky flags where an overflow wins over a clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            if (ovf_a && irq_en_a) begin
                flag_a <= 1'b1;
            end else if (clr_flag_a) begin
                flag_a <= 1'b0;
            end
            if (ovf_b && irq_en_b) begin
                flag_b <= 1'b1;
            end else if (clr_flag_b) begin
                flag_b <= 1'b0;
            end
            irq_n <= !(flag_a || flag_b);
        end
    end

    // Flags only move at a sample boundary when they rise
    assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(flag_a) || $rose(flag_b)) |-> $past(zero));

    // No interrupt left pending once both flags are gone
    assert property (@(posedge clk) disable iff (!rst_n)
        !(flag_a || flag_b) |=> irq_n);

endmodule

`default_nettype wire

//--- source/jt12_dac.sv
// DAC output path.
// Turns the offset-binary DAC byte into a signed sound word once per sample.
`default_nettype none

module jt12_dac (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               zero,
    input  wire  [7:0]                        dac_data,
    input  wire                               dac_en,
    output logic signed [jt12_pkg::SND_W-1:0] snd_out,
    output logic                              snd_sample
);

    import jt12_pkg::*;

    logic signed [8:0]       centred;   // -128..127
    logic signed [SND_W-1:0] extended;
    logic signed [SND_W-1:0] scaled;

    assign centred  = $signed({1'b0, dac_data}) - 9'sd128;
    assign extended = {{(SND_W - 9){centred[8]}}, centred};
    assign scaled   = extended <<< DAC_SHIFT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snd_out    <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= zero;
            if (zero) begin
                snd_out <= dac_en ? scaled : '0;  // Silent when disabled
            end
        end
    end

endmodule

`default_nettype wire

//--- source/jt12_top.sv
// Top level of the FM chip control core.
// Connects clock generation, register file, timers and the DAC path.
`default_nettype none

module jt12_top (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               cen,    // Tie high if unused
    input  wire  [7:0]                        din,
    input  wire  [1:0]                        addr,
    input  wire                               cs_n,
    input  wire                               wr_n,
    output logic [7:0]                        dout,
    output logic                              irq_n,
    output logic signed [jt12_pkg::SND_W-1:0] snd_out,
    output logic                              snd_sample
);

    import jt12_pkg::*;

    logic                 clk_en;
    logic                 zero;
    logic [TIMER_A_W-1:0] value_a;
    logic [TIMER_B_W-1:0] value_b;
    logic                 load_a;
    logic                 load_b;
    logic                 irq_en_a;
    logic                 irq_en_b;
    logic                 clr_flag_a;
    logic                 clr_flag_b;
    logic                 flag_a;
    logic                 flag_b;
    logic [7:0]           dac_data;
    logic                 dac_en;

    jt12_clkgen u_clkgen (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .cen    ( cen    ),
        .clk_en ( clk_en ),
        .zero   ( zero   )
    );

    jt12_regs u_regs (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .clk_en     ( clk_en     ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .flag_a     ( flag_a     ),
        .flag_b     ( flag_b     ),
        .dout       ( dout       ),
        .busy       (            ),   // Status bit 7 of dout
        .value_a    ( value_a    ),
        .value_b    ( value_b    ),
        .load_a     ( load_a     ),
        .load_b     ( load_b     ),
        .irq_en_a   ( irq_en_a   ),
        .irq_en_b   ( irq_en_b   ),
        .clr_flag_a ( clr_flag_a ),
        .clr_flag_b ( clr_flag_b ),
        .dac_data   ( dac_data   ),
        .dac_en     ( dac_en     )
    );

    jt12_timers u_timers (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .zero       ( zero       ),
        .value_a    ( value_a    ),
        .value_b    ( value_b    ),
        .load_a     ( load_a     ),
        .load_b     ( load_b     ),
        .irq_en_a   ( irq_en_a   ),
        .irq_en_b   ( irq_en_b   ),
        .clr_flag_a ( clr_flag_a ),
        .clr_flag_b ( clr_flag_b ),
        .flag_a     ( flag_a     ),
        .flag_b     ( flag_b     ),
        .irq_n      ( irq_n      )
    );

    jt12_dac u_dac (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .zero       ( zero       ),
        .dac_data   ( dac_data   ),
        .dac_en     ( dac_en     ),
        .snd_out    ( snd_out    ),
        .snd_sample ( snd_sample )
    );

endmodule

`default_nettype wire

//--- sim/tb_clk.sv
// Free-running testbench clock, period 10 time units.
// Instantiated once by the testbench top.
`default_nettype none

module tb_clk (
    output logic clk
);

    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

//--- sim/tb_top.sv
// Directed testbench for the FM chip control core.
// Runs reset, busy, timer A, timer B and DAC tests against jt12_top,
// prints one line per test and a closing summary.
`default_nettype none

module tb_top;

    import jt12_pkg::*;

    localparam int SAMPLE_CLKS = CEN_DIV * SAMPLE_DIV;   // 144
    localparam int BUSY_CLKS   = BUSY_LEN * CEN_DIV + 2;
    localparam int WRITE_CLKS  = BUSY_CLKS + 8;          // Bus cycle plus busy wait
    // Worst case length of each test
    localparam int RESET_CLKS  = 10;
    localparam int BUSYT_CLKS  = 2 * WRITE_CLKS + 10;
    localparam int TA_CLKS     = 5 * SAMPLE_CLKS + 5 * WRITE_CLKS;
    localparam int TB_CLKS     = (5 * TIMER_B_DIV + 1) * SAMPLE_CLKS + 4 * WRITE_CLKS;
    localparam int DAC_CLKS    = 6 * SAMPLE_CLKS + 4 * WRITE_CLKS;
    localparam int TIMEOUT     = 2 * (RESET_CLKS + BUSYT_CLKS + TA_CLKS + TB_CLKS + DAC_CLKS);

    logic                    clk;
    logic                    rst_n;
    logic                    cen;
    logic [7:0]              din;
    logic [1:0]              addr;
    logic                    cs_n;
    logic                    wr_n;
    logic [7:0]              dout;
    logic                    irq_n;
    logic signed [SND_W-1:0] snd_out;
    logic                    snd_sample;

    int checks = 0;
    int errors = 0;
    int tests  = 0;
    int cycles = 0;

    tb_clk clk_gen_inst (.clk(clk));

    jt12_top jt12_top_inst (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_out    ( snd_out    ),
        .snd_sample ( snd_sample )
    );

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("Test %-8s %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    // Address cycle then data cycle, bus released on the third edge
    task automatic bus_write(input logic [7:0] reg_addr, input logic [7:0] data);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= 2'b00;
        din  <= reg_addr;
        @(posedge clk);
        addr <= 2'b01;
        din  <= data;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        addr <= 2'b00;
        din  <= 8'h00;
    endtask

    task automatic addr_write(input logic [7:0] reg_addr);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= 2'b00;
        din  <= reg_addr;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic read_status(output logic [7:0] st);
        @(negedge clk);
        st = dout;                       // addr[0] is low between writes
    endtask

    task automatic wait_ready();
        logic [7:0] st;
        int n;
        n = 0;
        do begin
            read_status(st);
            n++;
        end while (st[7] && n < BUSY_CLKS);
        if (st[7]) begin
            report_failure($sformatf("busy still high %0d clocks after a write", n));
        end
    endtask

    task automatic write_reg(input logic [7:0] reg_addr, input logic [7:0] data);
        bus_write(reg_addr, data);
        wait_ready();
    endtask

    // Bit 8 is irq_n, bits 7..0 the status byte; seen_at is -1 on no match
    task automatic wait_level(input int idx, input logic level, input int clocks,
                              output int seen_at);
        logic [8:0] probe;
        seen_at = -1;
        for (int i = 0; i < clocks && seen_at < 0; i++) begin
            @(negedge clk);
            probe = {irq_n, dout};
            if (probe[idx] == level) begin
                seen_at = i;
            end
        end
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        @(negedge clk);
        while (!snd_sample && n < 2 * SAMPLE_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (!snd_sample) begin
            report_failure("no snd_sample pulse within 2 samples");
        end else begin
            @(negedge clk);
            expect_eq("snd_sample", 32'(snd_sample), 32'd0);  // One clock wide
        end
    endtask

    // Offset binary centred on 128, then scaled by the DAC shift
    function automatic int dac_expect(input logic [7:0] sample, input logic enabled);
        int centred;
        centred = int'(sample) - 128;
        return enabled ? centred * (1 << DAC_SHIFT) : 0;
    endfunction

    task automatic reset_values();
        int err0;
        err0 = errors;
        @(negedge clk);
        expect_eq("dout", 32'(dout), 32'h00);
        expect_eq("irq_n", 32'(irq_n), 32'd1);
        expect_eq("snd_out", int'(snd_out), 32'd0);
        end_test("reset", err0);
    endtask

    task automatic busy_flag();
        logic [7:0] st;
        int err0;
        err0 = errors;
        bus_write(REG_TIMER_B, 8'h00);
        read_status(st);
        expect_eq("busy", 32'(st[7]), 32'd1);
        wait_ready();
        addr_write(REG_DAC_DATA);        // Address cycle alone
        repeat (4) begin
            read_status(st);
            expect_eq("busy", 32'(st[7]), 32'd0);
        end
        end_test("busy", err0);
    endtask

    task automatic timer_a_irq();
        logic [7:0] st;
        int err0;
        int seen;
        err0 = errors;
        write_reg(REG_TIMER_A_HI, 8'hFF);    // 1020 >> 2
        write_reg(REG_TIMER_A_LO, 8'h00);
        bus_write(REG_TIMER_CTL, 8'h05);     // Load A, irq A on
        wait_level(0, 1'b1, 5 * SAMPLE_CLKS, seen);
        if (seen < 0) begin
            report_failure("flag_a did not set within 5 samples");
        end else if (seen < 3 * SAMPLE_CLKS) begin
            report_failure($sformatf("flag_a set early, %0d clocks after load", seen));
        end
        wait_level(8, 1'b0, 3, seen);
        if (seen < 0) begin
            report_failure("irq_n did not go low after flag_a set");
        end
        bus_write(REG_TIMER_CTL, 8'h15);     // Reset flag A, keep counting
        wait_level(8, 1'b1, 4, seen);
        if (seen < 0) begin
            report_failure("irq_n stayed low after the flag A reset");
        end
        read_status(st);
        expect_eq("flag_a", 32'(st[0]), 32'd0);
        wait_ready();
        write_reg(REG_TIMER_CTL, 8'h30);     // Stop timers, clear flags
        end_test("timer_a", err0);
    endtask

    task automatic timer_b_irq();
        int err0;
        int seen;
        err0 = errors;
        write_reg(REG_TIMER_B, 8'd254);
        bus_write(REG_TIMER_CTL, 8'h02);     // Load B, irq B off
        wait_level(1, 1'b1, 3 * TIMER_B_DIV * SAMPLE_CLKS, seen);
        if (seen >= 0) begin
            report_failure("flag_b set while its interrupt was disabled");
        end
        bus_write(REG_TIMER_CTL, 8'h0A);
        wait_level(1, 1'b1, (2 * TIMER_B_DIV + 1) * SAMPLE_CLKS, seen);
        if (seen < 0) begin
            report_failure("flag_b did not set within 33 samples");
        end
        wait_ready();
        write_reg(REG_TIMER_CTL, 8'h30);
        end_test("timer_b", err0);
    endtask

    task automatic dac_output();
        int err0;
        err0 = errors;
        write_reg(REG_DAC_EN, 8'h80);
        write_reg(REG_DAC_DATA, 8'hC0);
        wait_sample();
        expect_eq("snd_out", int'(snd_out), dac_expect(8'hC0, 1'b1));
        write_reg(REG_DAC_DATA, 8'h40);
        wait_sample();
        expect_eq("snd_out", int'(snd_out), dac_expect(8'h40, 1'b1));
        write_reg(REG_DAC_EN, 8'h00);
        wait_sample();
        expect_eq("snd_out", int'(snd_out), dac_expect(8'h40, 1'b0));
        end_test("dac", err0);
    endtask

    // Run limit in clocks
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: no result after %0d clocks", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        cen   = 1'b1;
        din   = 8'h00;
        addr  = 2'b00;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        busy_flag();
        timer_a_irq();
        timer_b_irq();
        dac_output();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/jt12_pkg.sv
source/jt12_clkgen.sv
source/jt12_regs.sv
source/jt12_timers.sv
source/jt12_dac.sv
source/jt12_top.sv
sim/tb_clk.sv
sim/tb_top.sv

//--- Makefile
# Verilator build, run and lint for the FM chip control core
TOP := tb_top
LOG := sim.log

all: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build lint clean
